/* source/multdiv_pkg.sv */
// ##############################
// Shared types and constants for the RV32M multiply/divide unit.
// Import into every module that handles requests.
// ##############################

package multdiv_pkg;

  // Data word width
  localparam int unsigned xlen = 32;

  // One operand half as seen by the 17x17 kernel
  localparam int unsigned half_w = 16;

  // Multiplier accumulator holds a 32-bit partial sum plus sign and carry
  localparam int unsigned acc_w = 34;

  // Long division runs one iteration per quotient bit
  localparam int unsigned div_steps = 32;

  // Width of the division step counter
  localparam int unsigned step_cnt_w = $clog2(div_steps);

  // Operator classes
  // MULH covers MULH, MULHSU and MULHU through signed_mode
  // DIV and REM cover the unsigned forms the same way
  typedef enum logic [1:0] {
    md_op_mull,
    md_op_mulh,
    md_op_div,
    md_op_rem
  } md_op_e;

  // One request to the unit
  // signed_mode bit 0 marks op_a as signed, bit 1 marks op_b as signed
  typedef struct packed {
    md_op_e          op;
    logic [1:0]      signed_mode;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
  } md_req_t;

endpackage

/* source/mul_fast.sv */
// ##############################
// Multiplier built on one 17x17 signed MAC kernel. MUL takes
// three kernel steps and the MULH forms take four.
// ##############################

`timescale 1ns/1ps

module mul_fast import multdiv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  md_req_t         req_i,
  output logic            done_o,
  output logic [xlen-1:0] result_o
);

  // One state per partial product
  typedef enum logic [1:0] {
    albl,
    albh,
    ahbl,
    ahbh
  } mul_state_e;

  mul_state_e mul_state_q;
  mul_state_e mul_state_d;

  logic [half_w-1:0]       half_a;
  logic [half_w-1:0]       half_b;
  logic                    sign_a;
  logic                    sign_b;
  logic signed [acc_w-1:0] accum;
  logic signed [acc_w-1:0] mac;
  logic [acc_w-1:0]        acc_q;
  logic [acc_w-1:0]        acc_d;
  logic                    done_q;
  logic                    done_d;
  logic                    is_mull;
  logic                    a_neg;
  logic                    b_neg;

  assign is_mull = (req_i.op == md_op_mull);
  assign a_neg   = req_i.signed_mode[0] & req_i.op_a[xlen-1];
  assign b_neg   = req_i.signed_mode[1] & req_i.op_b[xlen-1];

  // Kernel product plus accumulator
  // Two 17-bit factors always fit the 34-bit sum
  assign mac = $signed({sign_a, half_a}) * $signed({sign_b, half_b}) + $signed(accum);

  always_comb begin
    half_a      = req_i.op_a[half_w-1:0];
    half_b      = req_i.op_b[half_w-1:0];
    sign_a      = 1'b0;
    sign_b      = 1'b0;
    accum       = '0;
    acc_d       = acc_q;
    mul_state_d = mul_state_q;
    done_d      = 1'b0;

    unique case (mul_state_q)
      albl: begin
        // al*bl is unsigned and has no carry out of 32 bits
        if (start_i) begin
          acc_d       = mac;
          mul_state_d = albh;
        end
      end

      albh: begin
        half_b = req_i.op_b[xlen-1:half_w];
        sign_b = b_neg;
        accum  = acc_w'(acc_q[xlen-1:half_w]);
        if (is_mull) begin
          acc_d = acc_w'({mac[half_w-1:0], acc_q[half_w-1:0]});
        end else begin
          acc_d = mac;
        end
        mul_state_d = ahbl;
      end

      ahbl: begin
        half_a = req_i.op_a[xlen-1:half_w];
        sign_a = a_neg;
        if (is_mull) begin
          // Last step for MUL leaves the low word complete
          accum       = acc_w'(acc_q[xlen-1:half_w]);
          acc_d       = acc_w'({mac[half_w-1:0], acc_q[half_w-1:0]});
          done_d      = 1'b1;
          mul_state_d = albl;
        end else begin
          accum       = acc_q;
          acc_d       = mac;
          mul_state_d = ahbh;
        end
      end

      ahbh: begin
        half_a = req_i.op_a[xlen-1:half_w];
        half_b = req_i.op_b[xlen-1:half_w];
        sign_a = a_neg;
        sign_b = b_neg;
        // Upper partial sum shifted down with its sign
        accum       = {{half_w{acc_q[acc_w-1]}}, acc_q[acc_w-1:half_w]};
        acc_d       = mac;
        done_d      = 1'b1;
        mul_state_d = albl;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mul_state_q <= albl;
      done_q      <= 1'b0;
    end else begin
      mul_state_q <= mul_state_d;
      done_q      <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

  // Accumulator holds the finished word while idle
  assign done_o   = done_q;
  assign result_o = acc_q[xlen-1:0];

endmodule

/* source/div_long.sv */
// ##############################
// Restoring long divider for DIV, DIVU, REM and REMU. Works on
// magnitudes and fixes the sign at the end.
// ##############################

`timescale 1ns/1ps

module div_long import multdiv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  md_req_t         req_i,
  output logic            done_o,
  output logic [xlen-1:0] result_o
);

  typedef enum logic [2:0] {
    div_idle,
    div_abs_a,
    div_abs_b,
    div_comp,
    div_last,
    div_change_sign,
    div_finish
  } div_state_e;

  div_state_e div_state_q;
  div_state_e div_state_d;

  logic [xlen-1:0]       num_q;
  logic [xlen-1:0]       num_d;
  logic [xlen-1:0]       den_q;
  logic [xlen-1:0]       den_d;
  logic [xlen-1:0]       quo_q;
  logic [xlen-1:0]       quo_d;
  logic [xlen-1:0]       rem_q;
  logic [xlen-1:0]       rem_d;
  logic [step_cnt_w-1:0] cnt_q;
  logic [step_cnt_w-1:0] cnt_d;
  logic [step_cnt_w-1:0] cnt_dec;
  logic                  done_q;
  logic                  done_d;

  // Private subtractor with the borrow in bit xlen
  logic [xlen-1:0]       sub_a;
  logic [xlen-1:0]       sub_b;
  logic [xlen:0]         sub_res;

  logic                  is_div;
  logic                  div_zero;
  logic                  sign_a;
  logic                  sign_b;
  logic                  quo_neg;
  logic                  rem_neg;
  logic                  is_greater_equal;
  logic [xlen-1:0]       one_shift;
  logic [xlen-1:0]       next_rem;
  logic [xlen-1:0]       next_quo;

  assign is_div   = (req_i.op == md_op_div);
  assign div_zero = (req_i.op_b == '0);
  assign sign_a   = req_i.signed_mode[0] & req_i.op_a[xlen-1];
  assign sign_b   = req_i.signed_mode[1] & req_i.op_b[xlen-1];
  assign quo_neg  = sign_a ^ sign_b;
  assign rem_neg  = sign_a;

  assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};

  // Magnitudes are unsigned, so no borrow means remainder >= divisor
  assign is_greater_equal = ~sub_res[xlen];
  assign one_shift        = xlen'(1) << cnt_q;
  assign cnt_dec          = cnt_q - 1'b1;

  assign next_rem = is_greater_equal ? sub_res[xlen-1:0] : rem_q;
  assign next_quo = is_greater_equal ? (quo_q | one_shift) : quo_q;

  always_comb begin
    div_state_d = div_state_q;
    num_d       = num_q;
    den_d       = den_q;
    quo_d       = quo_q;
    rem_d       = rem_q;
    cnt_d       = cnt_q;
    done_d      = 1'b0;
    // Compare step by default
    sub_a       = rem_q;
    sub_b       = den_q;

    unique case (div_state_q)
      div_idle: begin
        if (start_i) begin
          div_state_d = div_abs_a;
        end
      end

      div_abs_a: begin
        sub_a = '0;
        sub_b = req_i.op_a;
        if (div_zero) begin
          // RV32M result for a zero divisor skips the whole iteration
          rem_d       = is_div ? '1 : req_i.op_a;
          div_state_d = div_finish;
        end else begin
          num_d       = sign_a ? sub_res[xlen-1:0] : req_i.op_a;
          quo_d       = '0;
          div_state_d = div_abs_b;
        end
      end

      div_abs_b: begin
        sub_a = '0;
        sub_b = req_i.op_b;
        den_d = sign_b ? sub_res[xlen-1:0] : req_i.op_b;
        // First partial remainder is the top numerator bit
        rem_d       = xlen'(num_q[xlen-1]);
        cnt_d       = step_cnt_w'(div_steps - 1);
        div_state_d = div_comp;
      end

      div_comp: begin
        rem_d = {next_rem[xlen-2:0], num_q[cnt_dec]};
        quo_d = next_quo;
        cnt_d = cnt_dec;
        if (cnt_q == step_cnt_w'(1)) begin
          div_state_d = div_last;
        end
      end

      div_last: begin
        // Only one of quotient and remainder is kept from here on
        rem_d       = is_div ? next_quo : next_rem;
        div_state_d = div_change_sign;
      end

      div_change_sign: begin
        sub_a = '0;
        sub_b = rem_q;
        if (is_div ? quo_neg : rem_neg) begin
          rem_d = sub_res[xlen-1:0];
        end
        div_state_d = div_finish;
      end

      div_finish: begin
        done_d      = 1'b1;
        div_state_d = div_idle;
      end

      default: begin
        div_state_d = div_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_state_q <= div_idle;
      cnt_q       <= '0;
      done_q      <= 1'b0;
    end else begin
      div_state_q <= div_state_d;
      cnt_q       <= cnt_d;
      done_q      <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    num_q <= num_d;
    den_q <= den_d;
    quo_q <= quo_d;
    rem_q <= rem_d;
  end

  // Result sits in the remainder register once finished
  assign done_o   = done_q;
  assign result_o = rem_q;

endmodule

/* source/multdiv_top.sv */
// ##############################
// Multiply/divide unit top level. Takes one request at a time and
// returns a single-cycle result strobe.
// ##############################

`timescale 1ns/1ps

module multdiv_top import multdiv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_valid_i,
  input  md_req_t         req_i,
  output logic            result_valid_o,
  output logic [xlen-1:0] result_o,
  output logic            busy_o
);

  md_req_t         req_q;
  logic            accept;
  logic            is_mul;
  logic            busy_q;
  logic            mul_start_q;
  logic            div_start_q;
  logic            mul_done;
  logic            div_done;
  logic [xlen-1:0] mul_result;
  logic [xlen-1:0] div_result;

  // Strobes arriving while busy are dropped
  assign accept = req_valid_i & ~busy_q;
  assign is_mul = (req_i.op == md_op_mull) || (req_i.op == md_op_mulh);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      mul_start_q <= 1'b0;
      div_start_q <= 1'b0;
    end else begin
      mul_start_q <= accept & is_mul;
      div_start_q <= accept & ~is_mul;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (result_valid_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Request stays stable for the engine until the next acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  mul_fast u_mul_fast (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (mul_start_q),
    .req_i    (req_q),
    .done_o   (mul_done),
    .result_o (mul_result)
  );

  div_long u_div_long (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (div_start_q),
    .req_i    (req_q),
    .done_o   (div_done),
    .result_o (div_result)
  );

  // Only one engine runs at a time
  assign result_valid_o = mul_done | div_done;
  assign result_o       = mul_done ? mul_result : div_result;
  assign busy_o         = busy_q;

endmodule

/* test/multdiv_assertions.sv */
// ##############################
// Checker bound into the multiply/divide top level. Keeps a
// reference model of each accepted request and checks value,
// latency and the busy flag with concurrent assertions.
// ##############################

`timescale 1ns/1ps

module multdiv_assertions import multdiv_pkg::*; (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            req_valid_i,
  input md_req_t         req_i,
  input logic            result_valid_i,
  input logic [xlen-1:0] result_i,
  input logic            busy_i
);

  logic            pending;
  int unsigned     wait_cycles;
  int unsigned     exp_latency;
  logic [xlen-1:0] exp_result;
  logic            accept;
  logic            fail_seen = 1'b0;

  // The model accepts a request only with nothing outstanding
  assign accept = req_valid_i & ~pending;

  // RV32M results from 64-bit arithmetic on the extended operands
  function automatic logic [xlen-1:0] expected_result(input md_req_t req);
    longint          a_ext;
    longint          b_ext;
    longint          wide;
    logic [xlen-1:0] res;
    a_ext = req.signed_mode[0] ? longint'($signed(req.op_a)) : longint'(req.op_a);
    b_ext = req.signed_mode[1] ? longint'($signed(req.op_b)) : longint'(req.op_b);
    wide  = a_ext * b_ext;
    res   = '0;
    case (req.op)
      md_op_mull: res = wide[31:0];
      md_op_mulh: res = wide[63:32];
      md_op_div: begin
        if (req.op_b == '0) begin
          res = '1;
        end else begin
          wide = a_ext / b_ext;
          res  = wide[31:0];
        end
      end
      default: begin
        if (req.op_b == '0) begin
          res = req.op_a;
        end else begin
          wide = a_ext % b_ext;
          res  = wide[31:0];
        end
      end
    endcase
    return res;
  endfunction

  // Cycles from the request edge to the result cycle
  function automatic int unsigned expected_latency(input md_req_t req);
    int unsigned lat;
    case (req.op)
      md_op_mull: lat = 3;
      md_op_mulh: lat = 4;
      default:    lat = (req.op_b == '0) ? 3 : 37;
    endcase
    return lat;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending     <= 1'b0;
      wait_cycles <= 0;
      exp_latency <= 0;
      exp_result  <= '0;
    end else if (accept) begin
      pending     <= 1'b1;
      wait_cycles <= 0;
      exp_latency <= expected_latency(req_i);
      exp_result  <= expected_result(req_i);
    end else if (pending) begin
      if (result_valid_i) begin
        pending <= 1'b0;
      end else begin
        wait_cycles <= wait_cycles + 1;
      end
    end
  end

  // Outputs stay quiet while reset is held
  reset_idle: assert property (@(posedge clk_i) !rst_ni |-> !busy_i && !result_valid_i)
    else begin
      fail_seen = 1'b1;
      $error("busy_o or result_valid_o active during reset");
    end

  // Busy covers acceptance through the result cycle
  busy_window: assert property (@(posedge clk_i) disable iff (!rst_ni) busy_i == pending)
    else begin
      fail_seen = 1'b1;
      $error("MISMATCH busy_o got %0h exp %0h", $sampled(busy_i), $sampled(pending));
    end

  strobe_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_i |-> pending)
    else begin
      fail_seen = 1'b1;
      $error("result strobe seen with no request outstanding");
    end

  result_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_i && pending |-> wait_cycles == exp_latency)
    else begin
      fail_seen = 1'b1;
      $error("result strobe came after %0d cycles instead of %0d",
             $sampled(wait_cycles), $sampled(exp_latency));
    end

  result_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_i && pending |-> result_i == exp_result)
    else begin
      fail_seen = 1'b1;
      $error("MISMATCH result_o got %08h exp %08h", $sampled(result_i), $sampled(exp_result));
    end

  result_missing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending && !result_valid_i |-> wait_cycles < exp_latency)
    else begin
      fail_seen = 1'b1;
      $error("no result strobe within %0d cycles of the request", $sampled(exp_latency));
    end

endmodule

bind multdiv_top multdiv_assertions u_assertions (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_valid_i    (req_valid_i),
  .req_i          (req_i),
  .result_valid_i (result_valid_o),
  .result_i       (result_o),
  .busy_i         (busy_o)
);

/* test/multdiv_tb.sv */
// ##############################
// Testbench for the multiply/divide unit. Sends directed and
// random requests one at a time while the bound checker models
// the results.
// ##############################

`timescale 1ns/1ps

module multdiv_tb import multdiv_pkg::*; ();

  localparam int unsigned rand_seed      = 32'hbe192f2b;
  localparam int unsigned directed_count = 44;
  localparam int unsigned random_count   = 40;
  localparam int unsigned num_requests   = directed_count + random_count;
  localparam int unsigned max_cycles     = 60 * num_requests;

  logic            clk_i;
  logic            rst_ni;
  logic            req_valid_i;
  md_req_t         req_i;
  logic            result_valid_o;
  logic [xlen-1:0] result_o;
  logic            busy_o;

  int unsigned     cycle_count = 0;
  logic            run_ended   = 1'b0;

  multdiv_top dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .busy_o         (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic report_failure(input string reason);
    run_ended = 1'b1;
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  // Hold the current position 2 ns after a rising edge until idle
  task automatic wait_idle();
    while (busy_o) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic issue_request(input md_op_e op, input logic [1:0] mode,
                               input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    wait_idle();
    req_i.op          = op;
    req_i.signed_mode = mode;
    req_i.op_a        = a;
    req_i.op_b        = b;
    req_valid_i       = 1'b1;
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
  endtask

  // MULH, MULHSU and MULHU around the extreme operands
  task automatic mul_high_corners();
    logic [xlen-1:0] ca [5];
    logic [xlen-1:0] cb [5];
    logic [1:0]      modes [3];
    ca    = '{32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h7fff_ffff};
    cb    = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000};
    modes = '{2'b11, 2'b01, 2'b00};
    foreach (modes[m]) begin
      foreach (ca[i]) begin
        issue_request(md_op_mulh, modes[m], ca[i], cb[i]);
      end
    end
  endtask

  // Every sign combination through DIV, DIVU, REM and REMU
  task automatic divide_table();
    logic [xlen-1:0] da [4];
    logic [xlen-1:0] db [4];
    da = '{32'hffff_fff9, 32'h0000_0007, 32'hffff_fff9, 32'h0000_0064};
    db = '{32'h0000_0002, 32'hffff_fffe, 32'hffff_fffe, 32'h0000_0007};
    foreach (da[i]) begin
      issue_request(md_op_div, 2'b11, da[i], db[i]);
      issue_request(md_op_div, 2'b00, da[i], db[i]);
      issue_request(md_op_rem, 2'b11, da[i], db[i]);
      issue_request(md_op_rem, 2'b00, da[i], db[i]);
    end
  endtask

  task automatic zero_divisor_cases();
    logic [xlen-1:0] za [2];
    za = '{32'h1234_5678, 32'h8000_0001};
    foreach (za[i]) begin
      issue_request(md_op_div, 2'b11, za[i], '0);
      issue_request(md_op_div, 2'b00, za[i], '0);
      issue_request(md_op_rem, 2'b11, za[i], '0);
      issue_request(md_op_rem, 2'b00, za[i], '0);
    end
  endtask

  task automatic random_mix(input int unsigned count);
    logic [31:0]     pick;
    md_op_e          op;
    logic [1:0]      mode;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    for (int i = 0; i < count; i++) begin
      pick = $urandom;
      a    = $urandom;
      b    = $urandom;
      op   = md_op_e'(pick[1:0]);
      if (op == md_op_mulh) begin
        // Mode 2 has no RV32M instruction
        mode = (pick[3:2] == 2'b10) ? 2'b11 : pick[3:2];
      end else begin
        mode = pick[2] ? 2'b11 : 2'b00;
      end
      // Zero and small divisors now and then
      if (op == md_op_div || op == md_op_rem) begin
        if (pick[6:4] == 3'd0) begin
          b = '0;
        end else if (pick[6:4] == 3'd1) begin
          b = b & 32'h0000_00ff;
        end else if (pick[6:4] == 3'd2) begin
          b = b | 32'hffff_ff00;
        end
      end
      issue_request(op, mode, a, b);
    end
  endtask

  initial begin
    void'($urandom(rand_seed));
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    issue_request(md_op_mull, 2'b11, 32'h0000_0003, 32'h0000_0007);
    issue_request(md_op_mull, 2'b11, 32'hffff_ffff, 32'hffff_ffff);
    issue_request(md_op_mull, 2'b11, 32'h8000_0000, 32'h0000_0002);
    mul_high_corners();
    divide_table();
    zero_divisor_cases();
    // Signed overflow case
    issue_request(md_op_div, 2'b11, 32'h8000_0000, 32'hffff_ffff);
    issue_request(md_op_rem, 2'b11, 32'h8000_0000, 32'hffff_ffff);
    random_mix(random_count);

    wait_idle();
    repeat (3) @(posedge clk_i);
    #2;
    if (dut.u_assertions.fail_seen) begin
      report_failure("an assertion in the bound checker failed");
    end else begin
      run_ended = 1'b1;
      $display("test passed");
      $finish;
    end
  end

  // Stop at the first failed check
  always @(posedge clk_i) begin
    if (dut.u_assertions.fail_seen) begin
      report_failure("an assertion in the bound checker failed");
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      report_failure("timeout, the request sequence did not finish in time");
    end
  end

  final begin
    if (!run_ended) begin
      $display("simulation stopped before the request sequence completed");
      $display("test failed");
    end
  end

endmodule

/* src.f */
source/multdiv_pkg.sv
source/mul_fast.sv
source/div_long.sv
source/multdiv_top.sv
test/multdiv_assertions.sv
test/multdiv_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := multdiv_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
VFLAGS     := --timing --assert --top-module $(TOP)
BUILD      := --binary -j 0 --Mdir $(OBJ_DIR)
SIM_ARGS   := +verilator+error+limit+10
PASS_MSG   := test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

build:
	$(VERILATOR) $(BUILD) $(VFLAGS) -f $(FILELIST)

# Pass only when the testbench printed its pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
